/* source/fetch_pkg.sv */
package fetch_pkg;

    // byte address as seen by fetch and memory
    typedef logic [31:0] addr_t;

    // memory transaction tag
    // 0 is reserved for no tag / no response
    typedef logic [3:0] mem_tag_t;

    // usable tags, also the miss tracker size
    localparam int num_mem_tags = 15;
    // blocks looked at from the pc's block onward
    localparam int prefetch_distance = 3;
    // max instructions handed to the buffer per cycle
    localparam int fetch_width = 4;

    // direct-mapped cache geometry, 8-byte blocks
    localparam int icache_lines = 32;
    localparam int icache_index_bits = $clog2(icache_lines);
    localparam int icache_tag_bits = 32 - 3 - icache_index_bits;

    typedef logic [icache_index_bits-1:0] icache_index_t;
    typedef logic [icache_tag_bits-1:0] icache_tag_t;

    // instruction buffer
    localparam int ibuff_depth = 8;
    localparam int ibuff_ptr_bits = $clog2(ibuff_depth);

    // holds 0 to 8
    typedef logic [3:0] ibuff_count_t;

    // one memory block
    // memory side uses the double word, fetch picks words
    // words[0] sits at the lower address
    typedef union packed {
        logic [63:0] dword;
        logic [1:0][31:0] words;
    } mem_block_t;

    typedef struct packed {
        logic valid;
        logic [31:0] inst;
        addr_t pc;
        addr_t npc;
    } inst_packet_t;

    typedef struct packed {
        logic en;
        addr_t addr;
    } mem_req_t;

    // tag 0 means nothing returned this cycle
    typedef struct packed {
        mem_tag_t tag;
        mem_block_t data;
    } mem_resp_t;

endpackage

/* source/icache.sv */
module icache (
    input  logic clock,
    input  logic arst_n,
    input  fetch_pkg::addr_t read_addr,
    output fetch_pkg::mem_block_t [fetch_pkg::prefetch_distance-1:0] read_blocks,
    output logic [fetch_pkg::prefetch_distance-1:0] read_hit,
    output logic [fetch_pkg::prefetch_distance-1:0] read_pending,
    input  logic alloc_en,
    input  fetch_pkg::addr_t alloc_addr,
    input  logic fill_en,
    input  fetch_pkg::addr_t fill_addr,
    input  fetch_pkg::mem_block_t fill_data
);
    import fetch_pkg::*;

    // per line storage
    icache_tag_t line_tag [icache_lines];
    mem_block_t line_data [icache_lines];
    logic [icache_lines-1:0] line_valid;
    logic [icache_lines-1:0] line_pending;

    addr_t [prefetch_distance-1:0] read_block_addrs;
    icache_index_t fill_index;
    icache_index_t alloc_index;
    logic fill_owned;

    // bits 2:0 are the offset inside the block
    function automatic icache_index_t index_of(addr_t a);
        return a[3 +: icache_index_bits];
    endfunction

    function automatic icache_tag_t tag_of(addr_t a);
        return a[31 -: icache_tag_bits];
    endfunction

    // three consecutive blocks starting at the read block
    always_comb begin
        for (int i = 0; i < prefetch_distance; i++) begin
            read_block_addrs[i] = {read_addr[31:3], 3'b000} + addr_t'(i * 8);
            read_blocks[i] = line_data[index_of(read_block_addrs[i])];
            read_hit[i] = line_valid[index_of(read_block_addrs[i])]
                && (line_tag[index_of(read_block_addrs[i])] == tag_of(read_block_addrs[i]));
            read_pending[i] = line_pending[index_of(read_block_addrs[i])]
                && (line_tag[index_of(read_block_addrs[i])] == tag_of(read_block_addrs[i]));
        end
    end

    assign fill_index = index_of(fill_addr);
    assign alloc_index = index_of(alloc_addr);

    // drop fills whose line was handed to another block meanwhile
    assign fill_owned = line_pending[fill_index] && (line_tag[fill_index] == tag_of(fill_addr));

    // valid and pending state
    // alloc comes last so it wins on the same line
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            line_valid <= '0;
            line_pending <= '0;
        end else begin
            if (fill_en && fill_owned) begin
                line_valid[fill_index] <= 1'b1;
                line_pending[fill_index] <= 1'b0;
            end
            if (alloc_en) begin
                line_valid[alloc_index] <= 1'b0;
                line_pending[alloc_index] <= 1'b1;
            end
        end
    end

    // tags and data
    always_ff @(posedge clock) begin
        if (fill_en && fill_owned) begin
            line_data[fill_index] <= fill_data;
        end
        // new owner of the line
        if (alloc_en) begin
            line_tag[alloc_index] <= tag_of(alloc_addr);
        end
    end

endmodule

/* source/miss_tracker.sv */
module miss_tracker (
    input  logic clock,
    input  logic arst_n,
    input  fetch_pkg::addr_t [fetch_pkg::prefetch_distance-1:0] lookup_addrs,
    output logic [fetch_pkg::prefetch_distance-1:0] lookup_hit,
    output logic full,
    input  logic record_en,
    input  fetch_pkg::mem_tag_t record_tag,
    input  fetch_pkg::addr_t record_addr,
    input  fetch_pkg::mem_tag_t resp_tag,
    output fetch_pkg::addr_t resp_addr,
    output logic resp_valid
);
    import fetch_pkg::*;

    // one entry per memory tag, tag 0 has none
    addr_t entry_addr [num_mem_tags:1];
    logic [num_mem_tags:1] entry_valid;

    // registered bits only
    // keeps request and free out of one combinational path
    assign full = &entry_valid;

    // block address match against every live entry
    always_comb begin
        for (int i = 0; i < prefetch_distance; i++) begin
            lookup_hit[i] = 1'b0;
            for (int t = 1; t <= num_mem_tags; t++) begin
                if (entry_valid[t] && (entry_addr[t][31:3] == lookup_addrs[i][31:3])) begin
                    lookup_hit[i] = 1'b1;
                end
            end
        end
    end

    // which block a returning tag belongs to
    always_comb begin
        resp_valid = 1'b0;
        resp_addr = '0;
        if (resp_tag != '0) begin
            resp_valid = entry_valid[resp_tag];
            resp_addr = entry_addr[resp_tag];
        end
    end

    // free on response, then record
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            entry_valid <= '0;
        end else begin
            if (resp_valid) begin
                entry_valid[resp_tag] <= 1'b0;
            end
            if (record_en) begin
                entry_valid[record_tag] <= 1'b1;
            end
        end
    end

    // address payload
    always_ff @(posedge clock) begin
        if (record_en) begin
            entry_addr[record_tag] <= record_addr;
        end
    end

endmodule

/* source/fetch.sv */
module fetch (
    input  logic clock,
    input  logic arst_n,
    input  logic redirect,
    input  fetch_pkg::addr_t redirect_pc,
    input  fetch_pkg::ibuff_count_t ibuff_free,
    output fetch_pkg::mem_req_t mem_req,
    input  fetch_pkg::mem_tag_t mem_accept_tag,
    input  fetch_pkg::mem_resp_t mem_resp,
    output fetch_pkg::inst_packet_t [fetch_pkg::fetch_width-1:0] out_insts,
    output logic [2:0] out_count
);
    import fetch_pkg::*;

    addr_t pc;
    addr_t [prefetch_distance-1:0] block_addrs;
    mem_block_t [prefetch_distance-1:0] cache_blocks;
    logic [prefetch_distance-1:0] cache_hit;
    logic [prefetch_distance-1:0] cache_pending;
    logic [prefetch_distance-1:0] tracker_hit;
    logic tracker_full;
    logic req_found;
    addr_t req_addr;
    logic req_accepted;
    addr_t resp_addr;
    logic resp_valid;
    logic hit_run;
    logic [2:0] hit_count;
    logic [2:0] next_count;
    logic [2:0] slot;
    ibuff_count_t space;
    inst_packet_t [fetch_width-1:0] next_insts;

    // blocks the tracker compares against
    always_comb begin
        for (int i = 0; i < prefetch_distance; i++) begin
            block_addrs[i] = {pc[31:3], 3'b000} + addr_t'(i * 8);
        end
    end

    // instructions available from consecutive hits
    // first block gives only its upper word if pc[2] is set
    always_comb begin
        hit_count = '0;
        hit_run = 1'b1;
        for (int i = 0; i < prefetch_distance; i++) begin
            hit_run = hit_run & cache_hit[i];
            if (hit_run) begin
                hit_count = hit_count + (((i == 0) && pc[2]) ? 3'd1 : 3'd2);
            end
        end
    end

    // buffer space not yet claimed by the registered group
    assign space = ibuff_free - ibuff_count_t'(out_count);

    // cap by fetch width, then by space
    always_comb begin
        next_count = (hit_count > 3'(fetch_width)) ? 3'(fetch_width) : hit_count;
        if (ibuff_count_t'(next_count) > space) begin
            next_count = space[2:0];
        end
    end

    // build packets, word slot counts from the first block's word 0
    always_comb begin
        slot = '0;
        for (int k = 0; k < fetch_width; k++) begin
            next_insts[k] = '0;
            slot = 3'(k) + {2'b00, pc[2]};
            if (3'(k) < next_count) begin
                next_insts[k].valid = 1'b1;
                next_insts[k].inst = cache_blocks[slot[2:1]].words[slot[0]];
                next_insts[k].pc = pc + addr_t'(k * 4);
                // no prediction, always fall through
                next_insts[k].npc = pc + addr_t'(k * 4 + 4);
            end
        end
    end

    // nearest block with no copy anywhere
    // scan from far to near so the nearest wins
    always_comb begin
        req_found = 1'b0;
        req_addr = '0;
        for (int i = prefetch_distance - 1; i >= 0; i--) begin
            if (!cache_hit[i] && !cache_pending[i] && !tracker_hit[i]) begin
                req_found = 1'b1;
                req_addr = block_addrs[i];
            end
        end
    end

    assign mem_req.en = req_found && !tracker_full;
    assign mem_req.addr = req_addr;

    // refused requests just retry later
    assign req_accepted = mem_req.en && (mem_accept_tag != '0);

    // pc and delivered count
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            pc <= '0;
            out_count <= '0;
        end else if (redirect) begin
            pc <= redirect_pc;
            out_count <= '0;
        end else begin
            pc <= pc + addr_t'({next_count, 2'b00});
            out_count <= next_count;
        end
    end

    // registered packets, cleared on redirect
    always_ff @(posedge clock) begin
        out_insts <= redirect ? '0 : next_insts;
    end

    icache icache_0 (
        .clock        (clock),
        .arst_n       (arst_n),
        .read_addr    (pc),
        .read_blocks  (cache_blocks),
        .read_hit     (cache_hit),
        .read_pending (cache_pending),
        .alloc_en     (req_accepted),
        .alloc_addr   (req_addr),
        .fill_en      (resp_valid),
        .fill_addr    (resp_addr),
        .fill_data    (mem_resp.data)
    );

    miss_tracker miss_tracker_0 (
        .clock        (clock),
        .arst_n       (arst_n),
        .lookup_addrs (block_addrs),
        .lookup_hit   (tracker_hit),
        .full         (tracker_full),
        .record_en    (req_accepted),
        .record_tag   (mem_accept_tag),
        .record_addr  (req_addr),
        .resp_tag     (mem_resp.tag),
        .resp_addr    (resp_addr),
        .resp_valid   (resp_valid)
    );

endmodule

/* source/inst_buffer.sv */
module inst_buffer (
    input  logic clock,
    input  logic arst_n,
    input  logic flush,
    input  fetch_pkg::inst_packet_t [fetch_pkg::fetch_width-1:0] in_insts,
    input  logic [2:0] in_count,
    input  logic take,
    output fetch_pkg::inst_packet_t head,
    output fetch_pkg::ibuff_count_t free
);
    import fetch_pkg::*;

    // circular storage
    inst_packet_t entries [ibuff_depth];
    logic [ibuff_ptr_bits-1:0] rd_ptr;
    logic [ibuff_ptr_bits-1:0] wr_ptr;
    ibuff_count_t count;
    logic pop;
    logic [fetch_width-1:0][ibuff_ptr_bits-1:0] wr_slot;

    // take only counts when something is there
    assign pop = take && (count != '0);

    assign free = ibuff_count_t'(ibuff_depth) - count;

    // oldest entry, valid tracks occupancy
    always_comb begin
        head = entries[rd_ptr];
        head.valid = (count != '0);
    end

    // write slots for the incoming group, wrapping
    always_comb begin
        for (int k = 0; k < fetch_width; k++) begin
            wr_slot[k] = wr_ptr + ibuff_ptr_bits'(k);
        end
    end

    // pointers and occupancy
    // flush drops the stored entries and the group arriving now
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count <= '0;
        end else if (flush) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count <= '0;
        end else begin
            wr_ptr <= wr_ptr + ibuff_ptr_bits'(in_count);
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + ibuff_count_t'(in_count) - ibuff_count_t'(pop);
        end
    end

    // packets in index order
    always_ff @(posedge clock) begin
        for (int k = 0; k < fetch_width; k++) begin
            if (!flush && (3'(k) < in_count)) begin
                entries[wr_slot[k]] <= in_insts[k];
            end
        end
    end

endmodule

/* source/fetch_top.sv */
module fetch_top (
    input  logic clock,
    input  logic arst_n,
    input  logic redirect,
    input  fetch_pkg::addr_t redirect_pc,
    output fetch_pkg::mem_req_t mem_req,
    input  fetch_pkg::mem_tag_t mem_accept_tag,
    input  fetch_pkg::mem_resp_t mem_resp,
    output fetch_pkg::inst_packet_t head,
    input  logic take
);
    import fetch_pkg::*;

    // fetch group into the buffer
    inst_packet_t [fetch_width-1:0] group_insts;
    logic [2:0] group_count;
    // buffer space back to fetch
    ibuff_count_t ibuff_free;

    fetch fetch_0 (
        .clock          (clock),
        .arst_n         (arst_n),
        .redirect       (redirect),
        .redirect_pc    (redirect_pc),
        .ibuff_free     (ibuff_free),
        .mem_req        (mem_req),
        .mem_accept_tag (mem_accept_tag),
        .mem_resp       (mem_resp),
        .out_insts      (group_insts),
        .out_count      (group_count)
    );

    // redirect also flushes whatever was buffered
    inst_buffer inst_buffer_0 (
        .clock    (clock),
        .arst_n   (arst_n),
        .flush    (redirect),
        .in_insts (group_insts),
        .in_count (group_count),
        .take     (take),
        .head     (head),
        .free     (ibuff_free)
    );

endmodule

/* tb/fetch_checker.sv */
module fetch_checker (
    input logic clock,
    input logic arst_n,
    input logic redirect,
    input fetch_pkg::mem_req_t mem_req,
    input fetch_pkg::mem_tag_t mem_accept_tag,
    input fetch_pkg::mem_resp_t mem_resp,
    input logic [2:0] out_count
);
    import fetch_pkg::*;

    // failed assertions so far
    int failures = 0;

    // tags in flight as seen on the memory port
    logic [num_mem_tags:1] tags_busy;

    // accept sets a tag, a response frees it
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            tags_busy <= '0;
        end else begin
            if (mem_resp.tag != '0) begin
                tags_busy[mem_resp.tag] <= 1'b0;
            end
            if (mem_req.en && (mem_accept_tag != '0)) begin
                tags_busy[mem_accept_tag] <= 1'b1;
            end
        end
    end

    // no request once every tag is in flight
    req_not_full: assert property (@(posedge clock) disable iff (!arst_n)
        !(mem_req.en && (&tags_busy)))
        else begin
            failures++;
            $error("memory request with all tags busy");
        end

    // whole blocks only
    req_aligned: assert property (@(posedge clock) disable iff (!arst_n)
        mem_req.en |-> (mem_req.addr[2:0] == 3'b000))
        else begin
            failures++;
            $error("memory request address not 8-byte aligned");
        end

    count_max: assert property (@(posedge clock) disable iff (!arst_n)
        out_count <= 3'd4)
        else begin
            failures++;
            $error("out_count above fetch width");
        end

    // output group dropped by the redirect
    redirect_clears: assert property (@(posedge clock) disable iff (!arst_n)
        redirect |=> (out_count == 3'd0))
        else begin
            failures++;
            $error("out_count not zero after redirect");
        end

endmodule

bind fetch fetch_checker fetch_checker_0 (
    .clock          (clock),
    .arst_n         (arst_n),
    .redirect       (redirect),
    .mem_req        (mem_req),
    .mem_accept_tag (mem_accept_tag),
    .mem_resp       (mem_resp),
    .out_count      (out_count)
);

/* tb/fetch_tb.sv */
module fetch_tb;
    import fetch_pkg::*;

    // word stored at byte address a is a ^ inst_key
    localparam logic [31:0] inst_key = 32'h1357_9bdf;
    localparam int num_rows = 7;

    // one stimulus row
    // take stays low for redirect_cycle cycles, then the optional redirect
    typedef struct packed {
        logic [7:0] redirect_cycle;
        logic do_redirect;
        addr_t redirect_pc;
        logic [7:0] take_mask;
        logic refuse;
        logic [15:0] insts;
    } row_t;

    localparam row_t rows [num_rows] = '{
        // plain stream from reset
        '{8'd0, 1'b0, 32'h0000_0000, 8'hff, 1'b0, 16'd40},
        // gaps in take
        '{8'd0, 1'b0, 32'h0000_0000, 8'b0101_1011, 1'b0, 16'd24},
        // target with bit 2 set
        '{8'd3, 1'b1, 32'h0000_0104, 8'hff, 1'b0, 16'd30},
        // buffer fills up while take is low
        '{8'd30, 1'b0, 32'h0000_0000, 8'hff, 1'b0, 16'd24},
        // refusals, shuffled responses
        '{8'd0, 1'b1, 32'h0000_0800, 8'hff, 1'b1, 16'd60},
        '{8'd5, 1'b1, 32'h0000_003c, 8'b1110_0111, 1'b1, 16'd40},
        // same cache lines as the start, other tag
        '{8'd2, 1'b1, 32'h0001_0004, 8'hff, 1'b1, 16'd30}
    };

    logic clock;
    logic arst_n;
    logic redirect;
    addr_t redirect_pc;
    mem_req_t mem_req;
    mem_tag_t mem_accept_tag;
    mem_resp_t mem_resp;
    inst_packet_t head;
    logic take;

    // memory model state, indexed by tag
    logic [num_mem_tags:1] tag_busy;
    addr_t tag_addr [num_mem_tags:1];
    int tag_due [num_mem_tags:1];
    int mem_cycle;
    logic refuse_phase;

    logic [31:0] lfsr = 32'h3b34_24d4;
    int checks;
    int errors;
    int dup_requests;

    fetch_top dut0 (
        .clock          (clock),
        .arst_n         (arst_n),
        .redirect       (redirect),
        .redirect_pc    (redirect_pc),
        .mem_req        (mem_req),
        .mem_accept_tag (mem_accept_tag),
        .mem_resp       (mem_resp),
        .head           (head),
        .take           (take)
    );

    always #5 clock = ~clock;

    // galois lfsr, one step per bit handed out
    function automatic logic next_random_bit();
        logic bit_out;
        bit_out = lfsr[0];
        lfsr = lfsr >> 1;
        if (bit_out) begin
            lfsr = lfsr ^ 32'h8020_0003;
        end
        return bit_out;
    endfunction

    function automatic logic [31:0] random_field(input int width);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < width; i++) begin
            value = {value[30:0], next_random_bit()};
        end
        return value;
    endfunction

    function automatic int total_insts();
        int sum;
        sum = 0;
        for (int i = 0; i < num_rows; i++) begin
            sum += int'(rows[i].insts);
        end
        return sum;
    endfunction

    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("error at %0t: %s is %h, expected %h", $time, what, actual, expected);
        end
    endtask

    // tagged memory, one response and one accept decision per cycle
    always @(negedge clock) begin
        mem_tag_t resp_tag;
        mem_tag_t new_tag;
        mem_resp_t resp;
        logic dup;
        resp_tag = '0;
        new_tag = '0;
        resp = '0;
        dup = 1'b0;
        if (!arst_n) begin
            tag_busy = '0;
        end else begin
            // lowest numbered due tag answers
            for (int t = num_mem_tags; t >= 1; t--) begin
                if (tag_busy[t] && (tag_due[t] <= mem_cycle)) begin
                    resp_tag = mem_tag_t'(t);
                end
            end
            if (resp_tag != '0) begin
                resp.tag = resp_tag;
                resp.data.words[0] = tag_addr[resp_tag] ^ inst_key;
                resp.data.words[1] = (tag_addr[resp_tag] + 32'd4) ^ inst_key;
            end
            if (mem_req.en) begin
                // same block asked for while still in flight
                for (int t = 1; t <= num_mem_tags; t++) begin
                    if (tag_busy[t] && (tag_addr[t] == mem_req.addr)) begin
                        dup = 1'b1;
                    end
                end
                if (dup) begin
                    dup_requests++;
                end
                check(32'(dup), 32'd0, "duplicate request flag");
                // half the requests bounce in a refusal phase
                if (!(refuse_phase && next_random_bit())) begin
                    for (int t = num_mem_tags; t >= 1; t--) begin
                        if (!tag_busy[t]) begin
                            new_tag = mem_tag_t'(t);
                        end
                    end
                end
                if (new_tag != '0) begin
                    tag_busy[new_tag] = 1'b1;
                    tag_addr[new_tag] = mem_req.addr;
                    // latency 1 to 8
                    tag_due[new_tag] = mem_cycle + 1 + int'(random_field(3));
                end
            end
            // freed only after the accept, so no reuse in its own response cycle
            if (resp_tag != '0) begin
                tag_busy[resp_tag] = 1'b0;
            end
        end
        mem_accept_tag <= new_tag;
        mem_resp <= resp;
        mem_cycle++;
    end

    initial begin
        row_t r;
        addr_t exp_pc;
        int remaining;
        int phase;
        int assert_fails;
        clock = 1'b0;
        arst_n = 1'b0;
        redirect = 1'b0;
        redirect_pc = '0;
        take = 1'b0;
        mem_accept_tag = '0;
        mem_resp = '0;
        refuse_phase = 1'b0;
        mem_cycle = 0;
        checks = 0;
        errors = 0;
        dup_requests = 0;
        exp_pc = '0;
        repeat (5) @(negedge clock);
        arst_n <= 1'b1;
        for (int i = 0; i < num_rows; i++) begin
            r = rows[i];
            // take low, head must show the next expected pc when valid
            for (int c = 0; c < int'(r.redirect_cycle); c++) begin
                @(negedge clock);
                take <= 1'b0;
                if (head.valid) begin
                    check(head.pc, exp_pc, "held head pc");
                end
            end
            if (!r.do_redirect && (r.redirect_cycle != '0)) begin
                check(32'(head.valid), 32'd1, "head valid after hold");
            end
            if (r.do_redirect) begin
                @(negedge clock);
                take <= 1'b0;
                redirect <= 1'b1;
                redirect_pc <= r.redirect_pc;
                // stream restarts at the target
                exp_pc = r.redirect_pc;
            end
            refuse_phase <= r.refuse;
            remaining = int'(r.insts);
            phase = 0;
            while (remaining > 0) begin
                @(negedge clock);
                redirect <= 1'b0;
                if (head.valid && r.take_mask[phase[2:0]]) begin
                    check(head.pc, exp_pc, "head pc");
                    check(head.npc, exp_pc + 32'd4, "head npc");
                    check(head.inst, exp_pc ^ inst_key, "head inst");
                    take <= 1'b1;
                    exp_pc = exp_pc + 32'd4;
                    remaining--;
                end else begin
                    take <= 1'b0;
                end
                phase++;
            end
        end
        @(negedge clock);
        take <= 1'b0;
        repeat (4) @(negedge clock);
        assert_fails = dut0.fetch_0.fetch_checker_0.failures;
        $display("checks %0d, value errors %0d, duplicate requests %0d, assertion failures %0d",
                 checks, errors, dup_requests, assert_fails);
        if ((errors == 0) && (assert_fails == 0)) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // run limit grows with the amount of stimulus
    initial begin
        int limit;
        int cycle_count;
        limit = total_insts() * 20 + 200;
        cycle_count = 0;
        while (cycle_count < limit) begin
            @(posedge clock);
            cycle_count++;
        end
        $display("timeout: stream did not complete within %0d cycles, %0d errors so far",
                 limit, errors);
        $display("Something failed");
        $finish;
    end

endmodule

/* files.f */
source/fetch_pkg.sv
source/icache.sv
source/miss_tracker.sv
source/fetch.sv
source/inst_buffer.sv
source/fetch_top.sv
tb/fetch_checker.sv
tb/fetch_tb.sv

/* Makefile */
# Verilator simulation of the fetch subsystem

VERILATOR ?= verilator
TOP       ?= fetch_tb
FILE_LIST ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Something failed
VFLAGS    ?= --binary --assert -Wno-fatal
RUN_ARGS  ?= +verilator+error+limit+1000

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)
	@$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "FAIL: see $(LOG)"; exit 1; \
	fi; \
	if [ $$status -ne 0 ]; then \
		echo "FAIL: simulator exit status $$status"; exit 1; \
	fi; \
	echo "PASS"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
